// ==== source/nocw_cfg.svh ====
`ifndef NOCW_CFG_SVH
`define NOCW_CFG_SVH

// ==========================================================================
// bus widths
// ==========================================================================
`define NOCW_ADDR_W   32
`define NOCW_DATA_W   32
`define NOCW_STRB_W   (`NOCW_DATA_W / 8)
`define NOCW_ID_W     4
`define NOCW_LEN_W    8
`define NOCW_SIZE_W   3

// ==========================================================================
// network
// ==========================================================================
`define NOCW_COORD_W  2
`define NOCW_BODY_W   48    // flit body, header or payload.
`define NOCW_BUF_DEPTH 2

`endif

// ==== source/nocw_axi_pkg.sv ====
`include "nocw_cfg.svh"

package nocw_axi_pkg;

  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01
  } axi_burst_e;

  typedef enum logic [1:0] {
    AXI_OKAY   = 2'b00,
    AXI_SLVERR = 2'b10,
    AXI_DECERR = 2'b11
  } axi_resp_e;

  // write address.
  typedef struct packed {
    logic [`NOCW_ID_W-1:0]   id;
    logic [`NOCW_ADDR_W-1:0] addr;
    logic [`NOCW_LEN_W-1:0]  len;    // beats minus one.
    logic [`NOCW_SIZE_W-1:0] size;
    axi_burst_e              burst;
  } axi_aw_t;

  // write data.
  typedef struct packed {
    logic [`NOCW_DATA_W-1:0] data;
    logic [`NOCW_STRB_W-1:0] strb;
    logic                    last;
  } axi_w_t;

  // write response.
  typedef struct packed {
    logic [`NOCW_ID_W-1:0] id;
    axi_resp_e             resp;
  } axi_b_t;

endpackage

// ==== source/nocw_noc_pkg.sv ====
`include "nocw_cfg.svh"

package nocw_noc_pkg;

  typedef struct packed {
    logic [`NOCW_COORD_W-1:0] x;
    logic [`NOCW_COORD_W-1:0] y;
  } location_t;

  typedef enum logic {
    ROUTING_XY = 1'b0,
    ROUTING_YX = 1'b1
  } routing_mode_e;

  // same code points as the axi response.
  typedef enum logic [1:0] {
    STATUS_OKAY   = 2'b00,
    STATUS_SLVERR = 2'b10,
    STATUS_DECERR = 2'b11
  } packet_status_e;

  typedef enum logic {
    FLIT_HEADER  = 1'b0,
    FLIT_PAYLOAD = 1'b1
  } flit_kind_e;

  // ==========================================================================
  // flit bodies, both exactly NOCW_BODY_W wide
  // ==========================================================================
  typedef struct packed {
    logic [`NOCW_BODY_W-`NOCW_LEN_W-`NOCW_SIZE_W-2-`NOCW_ADDR_W-1:0] pad;
    logic [`NOCW_LEN_W-1:0]  len;
    logic [`NOCW_SIZE_W-1:0] size;
    logic [1:0]              burst;
    logic [`NOCW_ADDR_W-1:0] addr;
  } header_body_t;

  typedef struct packed {
    logic [`NOCW_BODY_W-`NOCW_DATA_W-`NOCW_STRB_W-1:0] pad;
    logic [`NOCW_DATA_W-1:0] data;
    logic [`NOCW_STRB_W-1:0] strb;
  } payload_body_t;

  typedef struct packed {
    flit_kind_e              kind;
    logic                    tail;
    location_t               destination;
    location_t               source;
    routing_mode_e           routing_mode;
    logic [`NOCW_ID_W-1:0]   tag;
    logic                    invalid_destination;
    logic [`NOCW_BODY_W-1:0] body;
  } req_flit_t;

  // single-flit write response.
  typedef struct packed {
    location_t             destination;
    location_t             source;
    logic [`NOCW_ID_W-1:0] tag;
    packet_status_e        status;
  } rsp_flit_t;

endpackage

// ==== source/nocw_address_decoder.sv ====
`timescale 1ns/1ps
`include "nocw_cfg.svh"

module nocw_address_decoder (
  input  logic [`NOCW_ADDR_W-1:0] addr,
  output nocw_noc_pkg::location_t destination,
  output logic                    invalid
);

  // ==========================================================================
  // address map
  // ==========================================================================
  // region bits sit at the top, then x, then y.
  localparam int REGION_MSB = `NOCW_ADDR_W - 1;
  localparam int REGION_LSB = `NOCW_ADDR_W - 2;
  localparam int X_MSB      = REGION_LSB - 1;
  localparam int Y_MSB      = X_MSB - `NOCW_COORD_W;

  logic [REGION_MSB-REGION_LSB:0] region;

  assign region = addr[REGION_MSB:REGION_LSB];

  always_comb begin
    destination.x = addr[X_MSB -: `NOCW_COORD_W];
    destination.y = addr[Y_MSB -: `NOCW_COORD_W];
    invalid       = |region;    // only region zero is mapped.
  end

endmodule

// ==== source/nocw_packet_packer.sv ====
`timescale 1ns/1ps
`include "nocw_cfg.svh"

module nocw_packet_packer (
  input  logic                        clk,
  input  logic                        arst_n,
  input  nocw_noc_pkg::location_t     own_id,
  input  nocw_noc_pkg::routing_mode_e routing_mode,
  input  nocw_axi_pkg::axi_aw_t       aw,
  input  logic                        aw_valid,
  output logic                        aw_ready,
  input  nocw_axi_pkg::axi_w_t        w,
  input  logic                        w_valid,
  output logic                        w_ready,
  input  nocw_noc_pkg::location_t     destination,
  input  logic                        invalid_destination,
  output nocw_noc_pkg::req_flit_t     flit,
  output logic                        flit_valid,
  input  logic                        flit_ready
);
  import nocw_noc_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    HEADER,
    PAYLOAD
  } state_e;

  state_e                 state;
  state_e                 state_next;
  logic                   aw_fire;
  logic                   w_fire;
  logic                   flit_fire;
  logic [`NOCW_LEN_W-1:0] len_q;
  logic [`NOCW_LEN_W-1:0] beat_cnt;
  header_body_t           header_body;
  payload_body_t          payload_body;

  assign aw_fire   = aw_valid && aw_ready;
  assign w_fire    = w_valid && w_ready;
  assign flit_fire = flit_valid && flit_ready;

  // no new beat once the tail is sitting in the output register.
  assign w_ready = (state == PAYLOAD) && (!flit_valid || (flit_ready && !flit.tail));

  always_comb begin
    header_body       = '0;
    header_body.len   = aw.len;
    header_body.size  = aw.size;
    header_body.burst = aw.burst;
    header_body.addr  = aw.addr;
    payload_body      = '0;
    payload_body.data = w.data;
    payload_body.strb = w.strb;
  end

  // ==========================================================================
  // control
  // ==========================================================================
  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (aw_fire) state_next = HEADER;
      end
      HEADER: begin
        if (flit_fire) state_next = PAYLOAD;
      end
      PAYLOAD: begin
        if (flit_fire && flit.tail) state_next = IDLE;
      end
      default: state_next = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state      <= IDLE;
      aw_ready   <= 1'b0;
      flit_valid <= 1'b0;
      beat_cnt   <= '0;
    end else begin
      state    <= state_next;
      aw_ready <= (state_next == IDLE);
      if (aw_fire || w_fire) begin
        flit_valid <= 1'b1;
      end else if (flit_fire) begin
        flit_valid <= 1'b0;
      end
      if (aw_fire) begin
        beat_cnt <= '0;
      end else if (w_fire) begin
        beat_cnt <= beat_cnt + 1'b1;
      end
    end
  end

  // ==========================================================================
  // output flit register
  // ==========================================================================
  always_ff @(posedge clk) begin
    if (aw_fire) begin
      flit.kind                <= FLIT_HEADER;
      flit.tail                <= 1'b0;
      flit.destination         <= destination;
      flit.source              <= own_id;
      flit.routing_mode        <= routing_mode;
      flit.tag                 <= aw.id;
      flit.invalid_destination <= invalid_destination;
      flit.body                <= header_body;
      len_q                    <= aw.len;
    end else if (w_fire) begin
      flit.kind <= FLIT_PAYLOAD;    // routing fields kept from header.
      flit.tail <= w.last;
      flit.body <= payload_body;
    end
  end

  // held under back-pressure.
  assert property (@(posedge clk) disable iff (!arst_n)
    flit_valid && !flit_ready |=> flit_valid && $stable(flit));

  // wlast lands exactly on beat len.
  assert property (@(posedge clk) disable iff (!arst_n)
    w_fire && w.last |-> beat_cnt == len_q);

endmodule

// ==== source/nocw_packet_unpacker.sv ====
`timescale 1ns/1ps

module nocw_packet_unpacker (
  input  logic                    clk,
  input  logic                    arst_n,
  input  nocw_noc_pkg::rsp_flit_t flit,
  input  logic                    flit_valid,
  output logic                    flit_ready,
  output nocw_axi_pkg::axi_b_t    b,
  input  logic                    b_ready,
  output logic                    b_valid
);
  import nocw_axi_pkg::*;
  import nocw_noc_pkg::*;

  logic      flit_fire;
  axi_resp_e resp_map;

  assign flit_ready = !b_valid;    // one response held at a time.
  assign flit_fire  = flit_valid && flit_ready;

  always_comb begin
    case (flit.status)
      STATUS_SLVERR: resp_map = AXI_SLVERR;
      STATUS_DECERR: resp_map = AXI_DECERR;
      default:       resp_map = AXI_OKAY;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      b_valid <= 1'b0;
    end else if (flit_fire) begin
      b_valid <= 1'b1;
    end else if (b_ready) begin
      b_valid <= 1'b0;
    end
  end

  // tag goes back out as the axi id.
  always_ff @(posedge clk) begin
    if (flit_fire) begin
      b.id   <= flit.tag;
      b.resp <= resp_map;
    end
  end

  assert property (@(posedge clk) disable iff (!arst_n)
    b_valid && !b_ready |=> b_valid && $stable(b));

endmodule

// ==== source/nocw_flit_buffer.sv ====
`timescale 1ns/1ps
`include "nocw_cfg.svh"

module nocw_flit_buffer #(
  parameter type T     = nocw_noc_pkg::req_flit_t,
  parameter int  DEPTH = `NOCW_BUF_DEPTH
) (
  input  logic clk,
  input  logic arst_n,
  input  T     in_data,
  input  logic in_valid,
  output logic in_ready,
  output T     out_data,
  output logic out_valid,
  input  logic out_ready
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  T                 mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] count_next;
  logic             push;
  logic             pop;

  // wraps for depths that are not a power of two.
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) return '0;
    return ptr + 1'b1;
  endfunction

  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];

  always_comb begin
    count_next = count;
    if (push && !pop) count_next = count + 1'b1;
    else if (pop && !push) count_next = count - 1'b1;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      in_ready <= 1'b0;
    end else begin
      if (push) wr_ptr <= ptr_inc(wr_ptr);
      if (pop) rd_ptr <= ptr_inc(rd_ptr);
      count    <= count_next;
      in_ready <= (count_next != CNT_W'(DEPTH));    // registered full flag.
    end
  end

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= in_data;
  end

  assert property (@(posedge clk) disable iff (!arst_n)
    push |-> count < CNT_W'(DEPTH));

endmodule

// ==== source/nocw_axi_slave_write_adapter.sv ====
`timescale 1ns/1ps
`include "nocw_cfg.svh"

module nocw_axi_slave_write_adapter (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic [`NOCW_COORD_W-1:0]    id_x,
  input  logic [`NOCW_COORD_W-1:0]    id_y,
  input  nocw_noc_pkg::routing_mode_e routing_mode,
  input  nocw_axi_pkg::axi_aw_t       aw,
  input  logic                        aw_valid,
  output logic                        aw_ready,
  input  nocw_axi_pkg::axi_w_t        w,
  input  logic                        w_valid,
  output logic                        w_ready,
  output nocw_axi_pkg::axi_b_t        b,
  output logic                        b_valid,
  input  logic                        b_ready,
  output nocw_noc_pkg::req_flit_t     req_flit,
  output logic                        req_flit_valid,
  input  logic                        req_flit_ready,
  input  nocw_noc_pkg::rsp_flit_t     rsp_flit,
  input  logic                        rsp_flit_valid,
  output logic                        rsp_flit_ready
);
  import nocw_noc_pkg::*;

  location_t own_id;
  location_t destination;
  logic      invalid_destination;

  assign own_id = '{x: id_x, y: id_y};

  // ==========================================================================
  // request path
  // ==========================================================================
  nocw_address_decoder u_address_decoder (
    .addr        (aw.addr),
    .destination (destination),
    .invalid     (invalid_destination)
  );

  nocw_packet_packer u_packet_packer (
    .clk                 (clk),
    .arst_n              (arst_n),
    .own_id              (own_id),
    .routing_mode        (routing_mode),
    .aw                  (aw),
    .aw_valid            (aw_valid),
    .aw_ready            (aw_ready),
    .w                   (w),
    .w_valid             (w_valid),
    .w_ready             (w_ready),
    .destination         (destination),
    .invalid_destination (invalid_destination),
    .flit                (req_flit),
    .flit_valid          (req_flit_valid),
    .flit_ready          (req_flit_ready)
  );

  // ==========================================================================
  // response path
  // ==========================================================================
  nocw_packet_unpacker u_packet_unpacker (
    .clk        (clk),
    .arst_n     (arst_n),
    .flit       (rsp_flit),
    .flit_valid (rsp_flit_valid),
    .flit_ready (rsp_flit_ready),
    .b          (b),
    .b_ready    (b_ready),
    .b_valid    (b_valid)
  );

endmodule

// ==== source/nocw_axi_write_bridge.sv ====
`timescale 1ns/1ps
`include "nocw_cfg.svh"

module nocw_axi_write_bridge (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic [`NOCW_COORD_W-1:0]    id_x,
  input  logic [`NOCW_COORD_W-1:0]    id_y,
  input  nocw_noc_pkg::routing_mode_e routing_mode,
  input  nocw_axi_pkg::axi_aw_t       aw,
  input  logic                        aw_valid,
  output logic                        aw_ready,
  input  nocw_axi_pkg::axi_w_t        w,
  input  logic                        w_valid,
  output logic                        w_ready,
  output nocw_axi_pkg::axi_b_t        b,
  output logic                        b_valid,
  input  logic                        b_ready,
  output nocw_noc_pkg::req_flit_t     req_flit,
  output logic                        req_flit_valid,
  input  logic                        req_flit_ready,
  input  nocw_noc_pkg::rsp_flit_t     rsp_flit,
  input  logic                        rsp_flit_valid,
  output logic                        rsp_flit_ready
);
  import nocw_noc_pkg::*;

  req_flit_t pack_flit;
  logic      pack_flit_valid;
  logic      pack_flit_ready;
  rsp_flit_t unpack_flit;
  logic      unpack_flit_valid;
  logic      unpack_flit_ready;

  nocw_axi_slave_write_adapter u_adapter (
    .clk            (clk),
    .arst_n         (arst_n),
    .id_x           (id_x),
    .id_y           (id_y),
    .routing_mode   (routing_mode),
    .aw             (aw),
    .aw_valid       (aw_valid),
    .aw_ready       (aw_ready),
    .w              (w),
    .w_valid        (w_valid),
    .w_ready        (w_ready),
    .b              (b),
    .b_valid        (b_valid),
    .b_ready        (b_ready),
    .req_flit       (pack_flit),
    .req_flit_valid (pack_flit_valid),
    .req_flit_ready (pack_flit_ready),
    .rsp_flit       (unpack_flit),
    .rsp_flit_valid (unpack_flit_valid),
    .rsp_flit_ready (unpack_flit_ready)
  );

  nocw_flit_buffer #(.T(req_flit_t)) u_req_buffer (    // toward the network.
    .clk       (clk),
    .arst_n    (arst_n),
    .in_data   (pack_flit),
    .in_valid  (pack_flit_valid),
    .in_ready  (pack_flit_ready),
    .out_data  (req_flit),
    .out_valid (req_flit_valid),
    .out_ready (req_flit_ready)
  );

  nocw_flit_buffer #(.T(rsp_flit_t)) u_rsp_buffer (    // from the network.
    .clk       (clk),
    .arst_n    (arst_n),
    .in_data   (rsp_flit),
    .in_valid  (rsp_flit_valid),
    .in_ready  (rsp_flit_ready),
    .out_data  (unpack_flit),
    .out_valid (unpack_flit_valid),
    .out_ready (unpack_flit_ready)
  );

endmodule

// ==== sim/nocw_tb_tests.svh ====
`ifndef NOCW_TB_TESTS_SVH
`define NOCW_TB_TESTS_SVH

// expected flits follow the address map: x from 29:28, y from 27:26.
function automatic req_flit_t exp_header(input axi_aw_t a);
  req_flit_t    f;
  header_body_t hb;
  hb                    = '0;
  hb.len                = a.len;
  hb.size               = a.size;
  hb.burst              = a.burst;
  hb.addr               = a.addr;
  f.kind                = FLIT_HEADER;
  f.tail                = 1'b0;
  f.destination         = '{x: a.addr[29:28], y: a.addr[27:26]};
  f.source              = '{x: ID_X, y: ID_Y};
  f.routing_mode        = routing_mode;
  f.tag                 = a.id;
  f.invalid_destination = |a.addr[31:30];
  f.body                = hb;
  return f;
endfunction

function automatic req_flit_t exp_payload(input req_flit_t hdr, input axi_w_t beat);
  payload_body_t pb;
  pb       = '0;
  pb.data  = beat.data;
  pb.strb  = beat.strb;
  hdr.kind = FLIT_PAYLOAD;
  hdr.tail = beat.last;
  hdr.body = pb;
  return hdr;
endfunction

function automatic axi_b_t exp_b(input axi_aw_t a);
  return '{id: a.id, resp: (|a.addr[31:30]) ? AXI_DECERR : AXI_OKAY};
endfunction

function automatic axi_aw_t mk_aw(input logic [3:0] id, input logic [31:0] addr,
                                  input int len, input axi_burst_e burst);
  return '{id: id, addr: addr, len: len[7:0], size: 3'd2, burst: burst};
endfunction

task automatic make_beats(input int n, output axi_w_t beats[$]);
  axi_w_t beat;
  beats = {};
  for (int i = 0; i < n; i++) begin
    beat.data = rand_bits(32);
    beat.strb = 4'(rand_bits(4));
    beat.last = (i == n - 1);
    beats.push_back(beat);
  end
endtask

// ==========================================================================
// channel drivers
// ==========================================================================
task automatic write_burst(input axi_aw_t a, input axi_w_t beats[$]);
  int n;
  n = 0;
  @(posedge clk);
  aw       <= a;
  aw_valid <= 1'b1;
  @(negedge clk);
  while (!aw_ready && n < TIMEOUT) begin
    @(negedge clk);
    n++;
  end
  if (!aw_ready) note_timeout("aw_ready");
  @(posedge clk);
  aw_valid <= 1'b0;
  foreach (beats[i]) begin
    w       <= beats[i];
    w_valid <= 1'b1;
    n = 0;
    @(negedge clk);
    while (!w_ready && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!w_ready) note_timeout("w_ready");
    @(posedge clk);
  end
  w_valid <= 1'b0;
endtask

task automatic send_rsp(input rsp_flit_t r);
  int n;
  n = 0;
  @(posedge clk);
  rsp_flit       <= r;
  rsp_flit_valid <= 1'b1;
  @(negedge clk);
  while (!rsp_flit_ready && n < TIMEOUT) begin
    @(negedge clk);
    n++;
  end
  if (!rsp_flit_ready) note_timeout("rsp_flit_ready");
  @(posedge clk);
  rsp_flit_valid <= 1'b0;
endtask

// endpoint answer to one header.
task automatic respond(input req_flit_t hdr);
  rsp_flit_t r;
  r.destination = hdr.source;
  r.source      = hdr.destination;
  r.tag         = hdr.tag;
  r.status      = hdr.invalid_destination ? STATUS_DECERR : STATUS_OKAY;
  send_rsp(r);
endtask

task automatic collect_packet(output req_flit_t flits[$]);
  int        n;
  req_flit_t f;
  flits = {};
  forever begin
    n = 0;
    while (req_q.size() == 0 && n < TIMEOUT) begin
      @(posedge clk);
      n++;
    end
    if (req_q.size() == 0) begin
      note_timeout("a request flit");
      return;
    end
    f = req_q.pop_front();
    flits.push_back(f);
    if (f.tail) return;
  end
endtask

task automatic wait_b(output axi_b_t got, output logic ok);
  int n;
  n  = 0;
  ok = 1'b0;
  got = '0;
  while (b_q.size() == 0 && n < TIMEOUT) begin
    @(posedge clk);
    n++;
  end
  if (b_q.size() == 0) begin
    note_timeout("a B beat");
    return;
  end
  got = b_q.pop_front();
  ok  = 1'b1;
endtask

task automatic check_packet(input axi_aw_t a, input axi_w_t beats[$], input req_flit_t flits[$]);
  req_flit_t exp;
  check_count("flit count", beats.size() + 1, flits.size());
  if (flits.size() != beats.size() + 1) return;
  exp = exp_header(a);
  check_req_flit("req_flit header", exp, flits[0]);
  foreach (beats[i]) check_req_flit("req_flit payload", exp_payload(exp, beats[i]), flits[i + 1]);
endtask

// ==========================================================================
// directed tests
// ==========================================================================
task automatic run_write(input axi_aw_t a);
  axi_w_t    beats[$];
  req_flit_t flits[$];
  axi_b_t    got;
  logic      ok;
  make_beats(int'(a.len) + 1, beats);
  write_burst(a, beats);
  collect_packet(flits);
  check_packet(a, beats, flits);
  if (flits.size() == 0) return;
  respond(flits[0]);
  wait_b(got, ok);
  if (ok) check_rsp_b("b", exp_b(a), got);
endtask

task automatic test_single_write();
  run_write(mk_aw(4'h3, 32'h1400_0010, 0, BURST_INCR));
endtask

task automatic test_incr_burst();
  run_write(mk_aw(4'h6, 32'h2800_0040, 3, BURST_INCR));
endtask

task automatic test_invalid_address();
  run_write(mk_aw(4'hB, 32'h8C00_0080, 1, BURST_FIXED));    // region 2.
endtask

task automatic test_back_pressure();
  stall_req = 1'b1;
  stall_b   = 1'b1;
  run_write(mk_aw(4'h7, 32'h3C00_0100, 3, BURST_INCR));
  run_write(mk_aw(4'hA, 32'h0400_0200, 1, BURST_INCR));
  stall_req = 1'b0;
  stall_b   = 1'b0;
endtask

task automatic test_reordered_responses();
  axi_aw_t   aws[3];
  axi_w_t    beats[$];
  req_flit_t flits[$];
  req_flit_t hdrs[$];
  axi_b_t    got;
  logic      ok;
  int        b_cnt;
  aws[0] = mk_aw(4'h5, 32'h0C00_0000, 1, BURST_INCR);
  aws[1] = mk_aw(4'h9, 32'h1800_0020, 0, BURST_INCR);
  aws[2] = mk_aw(4'hC, 32'h2400_0030, 2, BURST_INCR);
  b_cnt  = 0;
  for (int i = 0; i < 3; i++) begin
    make_beats(int'(aws[i].len) + 1, beats);
    write_burst(aws[i], beats);
    collect_packet(flits);
    check_packet(aws[i], beats, flits);
    if (flits.size() > 0) hdrs.push_back(flits[0]);
  end
  check_count("collected headers", 3, hdrs.size());
  // answer the newest first.
  for (int i = hdrs.size() - 1; i >= 0; i--) begin
    respond(hdrs[i]);
    wait_b(got, ok);
    if (ok) begin
      b_cnt++;
      check_rsp_b("b", exp_b(aws[i]), got);
    end
  end
  check_count("b beats", 3, b_cnt);
endtask

`endif

// ==== sim/nocw_tb.sv ====
`timescale 1ns/1ps

module nocw_tb;
  import nocw_axi_pkg::*;
  import nocw_noc_pkg::*;

  localparam int TIMEOUT = 200;    // cycles per wait.
  localparam logic [1:0] ID_X = 2'd1;
  localparam logic [1:0] ID_Y = 2'd2;

  logic          clk;
  logic          arst_n;
  axi_aw_t       aw;
  logic          aw_valid;
  logic          aw_ready;
  axi_w_t        w;
  logic          w_valid;
  logic          w_ready;
  axi_b_t        b;
  logic          b_valid;
  logic          b_ready;
  req_flit_t     req_flit;
  logic          req_flit_valid;
  logic          req_flit_ready;
  rsp_flit_t     rsp_flit;
  logic          rsp_flit_valid;
  logic          rsp_flit_ready;
  routing_mode_e routing_mode;

  logic [15:0] lfsr = 16'd26083;
  logic        stall_req;
  logic        stall_b;
  req_flit_t   req_q[$];    // flits taken by the endpoint.
  axi_b_t      b_q[$];
  int          checks;
  int          errors;
  int          timeouts;

  nocw_axi_write_bridge DUT (
    .clk            (clk),
    .arst_n         (arst_n),
    .id_x           (ID_X),
    .id_y           (ID_Y),
    .routing_mode   (routing_mode),
    .aw             (aw),
    .aw_valid       (aw_valid),
    .aw_ready       (aw_ready),
    .w              (w),
    .w_valid        (w_valid),
    .w_ready        (w_ready),
    .b              (b),
    .b_valid        (b_valid),
    .b_ready        (b_ready),
    .req_flit       (req_flit),
    .req_flit_valid (req_flit_valid),
    .req_flit_ready (req_flit_ready),
    .rsp_flit       (rsp_flit),
    .rsp_flit_valid (rsp_flit_valid),
    .rsp_flit_ready (rsp_flit_ready)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ==========================================================================
  // random source and compare tasks
  // ==========================================================================
  function automatic logic rand_bit();
    logic bit_out;
    bit_out = lfsr[0];
    lfsr    = lfsr >> 1;
    if (bit_out) lfsr = lfsr ^ 16'hB400;    // galois taps.
    return bit_out;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) r = {r[30:0], rand_bit()};
    return r;
  endfunction

  task automatic check_req_flit(input string name, input req_flit_t exp, input req_flit_t got);
    checks++;
    if (exp !== got) begin
      errors++;
      $display("ERROR %s expected %h got %h", name, exp, got);
    end
  endtask

  task automatic check_rsp_b(input string name, input axi_b_t exp, input axi_b_t got);
    checks++;
    if (exp !== got) begin
      errors++;
      $display("ERROR %s expected %h got %h", name, exp, got);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int got);
    checks++;
    if (exp != got) begin
      errors++;
      $display("ERROR %s expected %h got %h", name, exp, got);
    end
  endtask

  task automatic note_timeout(input string what);
    timeouts++;
    $display("timeout while waiting for %s", what);
  endtask

  `include "nocw_tb_tests.svh"

  // ==========================================================================
  // remote endpoint sinks
  // ==========================================================================
  task automatic req_sink();
    forever begin
      @(negedge clk);
      if (req_flit_valid && req_flit_ready) req_q.push_back(req_flit);
      @(posedge clk);
      req_flit_ready <= stall_req ? rand_bit() : 1'b1;
    end
  endtask

  task automatic b_sink();
    forever begin
      @(negedge clk);
      if (b_valid && b_ready) b_q.push_back(b);
      @(posedge clk);
      b_ready <= stall_b ? rand_bit() : 1'b1;
    end
  endtask

  initial begin
    arst_n         = 1'b0;
    aw             = '0;
    aw_valid       = 1'b0;
    w              = '0;
    w_valid        = 1'b0;
    b_ready        = 1'b0;
    req_flit_ready = 1'b0;
    rsp_flit       = '0;
    rsp_flit_valid = 1'b0;
    routing_mode   = ROUTING_YX;
    stall_req      = 1'b0;
    stall_b        = 1'b0;
    checks         = 0;
    errors         = 0;
    timeouts       = 0;
    repeat (5) @(posedge clk);
    arst_n <= 1'b1;
    fork
      req_sink();
      b_sink();
    join_none
    test_single_write();
    test_incr_burst();
    test_invalid_address();
    test_back_pressure();
    test_reordered_responses();
    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+source
+incdir+sim
source/nocw_axi_pkg.sv
source/nocw_noc_pkg.sv
source/nocw_address_decoder.sv
source/nocw_packet_packer.sv
source/nocw_packet_unpacker.sv
source/nocw_flit_buffer.sv
source/nocw_axi_slave_write_adapter.sv
source/nocw_axi_write_bridge.sv
sim/nocw_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -f compile.f --top-module nocw_tb -o nocw_sim
./obj_dir/nocw_sim | tee sim.log

if grep -q "Verification failed" sim.log; then
  exit 1
fi
